// ==== logic/rvm_settings.svh ====
`ifndef RVM_SETTINGS_SVH
`define RVM_SETTINGS_SVH

// Operand and result width
`define RVM_XLEN 32

// Architectural registers, x0 included
`define RVM_NREGS 32

// Width of the instruction ID tag
`define RVM_ID_W 4

// Depth of the arithmetic pipeline
`define RVM_STAGES 5

`endif

// ==== logic/rvm_pkg.sv ====
`default_nettype none

`include "rvm_settings.svh"

package rvm_pkg;

    localparam int unsigned REG_AW = $clog2(`RVM_NREGS);

    // Encoded as funct3
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } rvm_op_e;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } rvm_rtype_t;

    typedef union packed {
        logic [31:0] raw;
        rvm_rtype_t  r;
    } rvm_instr_u;

    typedef struct packed {
        rvm_op_e              op;
        logic [`RVM_XLEN-1:0] a;
        logic [`RVM_XLEN-1:0] b;
        logic [REG_AW-1:0]    rd;
        logic                 we;
        logic                 illegal;
        logic [`RVM_ID_W-1:0] id;
    } rvm_issue_t;

    typedef struct packed {
        logic              we;
        logic [REG_AW-1:0] rd;
    } rvm_dest_t;

    typedef struct packed {
        logic                 valid;
        logic [`RVM_XLEN-1:0] result;
        logic [REG_AW-1:0]    rd;
        logic                 we;
        logic                 illegal;
        logic [`RVM_ID_W-1:0] id;
    } rvm_wb_t;

endpackage : rvm_pkg

`default_nettype wire

// ==== logic/rvm_decode.sv ====
`default_nettype none

`include "rvm_settings.svh"

module rvm_decode (
    input  logic                                      instr_valid_i,
    input  rvm_pkg::rvm_instr_u                       instr_i,
    input  logic [`RVM_ID_W-1:0]                      instr_id_i,
    input  logic [`RVM_XLEN-1:0]                      rs1_data_i,
    input  logic [`RVM_XLEN-1:0]                      rs2_data_i,
    input  rvm_pkg::rvm_dest_t [`RVM_STAGES-1:0]      stage_dest_i,

    output logic                                      instr_ready_o,
    output logic [rvm_pkg::REG_AW-1:0]                rs1_addr_o,
    output logic [rvm_pkg::REG_AW-1:0]                rs2_addr_o,
    output logic                                      issue_valid_o,
    output rvm_pkg::rvm_issue_t                       issue_o
);

    import rvm_pkg::*;

    localparam int unsigned STAGES = `RVM_STAGES;

    // OP opcode with funct7 = 0000001, funct3 free
    localparam logic [31:0] M_MASK  = 32'hfe00_007f;
    localparam logic [31:0] M_MATCH = 32'h0200_0033;

    logic              legal;
    logic              hazard;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;

    assign legal = (instr_i.raw & M_MASK) == M_MATCH;

    assign rs1 = instr_i.r.rs1;
    assign rs2 = instr_i.r.rs2;
    assign rd  = instr_i.r.rd;

    assign rs1_addr_o = rs1;
    assign rs2_addr_o = rs2;

    // The last stage sits on the writeback port, which the register file
    // reads through, so only the stages before it can hold an issue
    always_comb begin
        hazard = 1'b0;
        for (int s = 0; s < STAGES - 1; s++) begin
            if (stage_dest_i[s].we && stage_dest_i[s].rd != '0) begin
                if (stage_dest_i[s].rd == rs1 || stage_dest_i[s].rd == rs2) begin
                    hazard = 1'b1;
                end
            end
        end
    end

    // Illegal words read nothing, never stall
    assign instr_ready_o = !legal || !hazard;
    assign issue_valid_o = instr_valid_i && instr_ready_o;

    always_comb begin
        issue_o.op      = rvm_op_e'(instr_i.r.funct3);
        issue_o.a       = rs1_data_i;
        issue_o.b       = rs2_data_i;
        issue_o.rd      = rd;
        issue_o.we      = legal && rd != '0;
        issue_o.illegal = !legal;
        issue_o.id      = instr_id_i;
    end

endmodule : rvm_decode

`default_nettype wire

// ==== logic/rvm_pipeline.sv ====
`default_nettype none

`include "rvm_settings.svh"

module rvm_pipeline (
    input  logic                                   clk_i,
    input  logic                                   arst_n_i,

    input  logic                                   issue_valid_i,
    input  rvm_pkg::rvm_issue_t                    issue_i,

    output rvm_pkg::rvm_dest_t [`RVM_STAGES-1:0]   stage_dest_o,
    output rvm_pkg::rvm_wb_t                       wb_o
);

    import rvm_pkg::*;

    localparam int unsigned XLEN   = `RVM_XLEN;
    localparam int unsigned STAGES = `RVM_STAGES;

    localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic [XLEN-1:0]        a;
    logic [XLEN-1:0]        b;
    logic [XLEN-1:0]        b_safe;
    logic                   div_zero;
    logic                   div_ovf;

    logic signed [2*XLEN-1:0] prod_ss;
    logic signed [2*XLEN-1:0] prod_su;
    logic        [2*XLEN-1:0] prod_uu;
    logic signed [XLEN-1:0]   quot_s;
    logic signed [XLEN-1:0]   rem_s;
    logic        [XLEN-1:0]   quot_u;
    logic        [XLEN-1:0]   rem_u;

    logic [XLEN-1:0]        result;

    // Stage control with reset
    logic [STAGES-1:0]      valid_q;
    logic [STAGES-1:0]      we_q;

    // Stage payload
    logic [XLEN-1:0]        result_q  [STAGES];
    logic [REG_AW-1:0]      rd_q      [STAGES];
    logic                   illegal_q [STAGES];
    logic [`RVM_ID_W-1:0]   id_q      [STAGES];

    assign a = issue_i.a;
    assign b = issue_i.b;

    assign div_zero = b == '0;
    assign div_ovf  = a == MOST_NEG && b == '1;

    // Keeps the dividers defined when b is zero
    assign b_safe = div_zero ? XLEN'(1) : b;

    always_comb begin
        prod_ss = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{b[XLEN-1]}}, b});
        prod_su = $signed({{XLEN{a[XLEN-1]}}, a}) * $signed({{XLEN{1'b0}}, b});
        prod_uu = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        quot_s  = $signed(a) / $signed(b_safe);
        rem_s   = $signed(a) % $signed(b_safe);
        quot_u  = a / b_safe;
        rem_u   = a % b_safe;
    end

    always_comb begin
        unique case (issue_i.op)
            OP_MUL:    result = prod_ss[XLEN-1:0];
            OP_MULH:   result = prod_ss[2*XLEN-1:XLEN];
            OP_MULHSU: result = prod_su[2*XLEN-1:XLEN];
            OP_MULHU:  result = prod_uu[2*XLEN-1:XLEN];
            OP_DIV: begin
                if (div_zero) begin
                    result = '1;
                end else if (div_ovf) begin
                    result = a;
                end else begin
                    result = quot_s;
                end
            end
            OP_DIVU:   result = div_zero ? '1 : quot_u;
            OP_REM: begin
                if (div_zero) begin
                    result = a;
                end else if (div_ovf) begin
                    result = '0;
                end else begin
                    result = rem_s;
                end
            end
            OP_REMU:   result = div_zero ? a : rem_u;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            we_q    <= '0;
        end else begin
            valid_q <= {valid_q[STAGES-2:0], issue_valid_i};
            we_q    <= {we_q[STAGES-2:0], issue_valid_i && issue_i.we};
        end
    end

    always_ff @(posedge clk_i) begin
        result_q[0]  <= result;
        rd_q[0]      <= issue_i.rd;
        illegal_q[0] <= issue_i.illegal;
        id_q[0]      <= issue_i.id;
        for (int s = 1; s < STAGES; s++) begin
            result_q[s]  <= result_q[s-1];
            rd_q[s]      <= rd_q[s-1];
            illegal_q[s] <= illegal_q[s-1];
            id_q[s]      <= id_q[s-1];
        end
    end

    // Destination reports for the hazard check
    always_comb begin
        for (int s = 0; s < STAGES; s++) begin
            stage_dest_o[s].we = valid_q[s] && we_q[s];
            stage_dest_o[s].rd = rd_q[s];
        end
    end

    always_comb begin
        wb_o.valid   = valid_q[STAGES-1];
        wb_o.result  = result_q[STAGES-1];
        wb_o.rd      = rd_q[STAGES-1];
        wb_o.we      = we_q[STAGES-1];
        wb_o.illegal = illegal_q[STAGES-1];
        wb_o.id      = id_q[STAGES-1];
    end

endmodule : rvm_pipeline

`default_nettype wire

// ==== logic/rvm_regfile.sv ====
`default_nettype none

`include "rvm_settings.svh"

module rvm_regfile (
    input  logic                            clk_i,
    input  logic                            arst_n_i,

    input  logic [rvm_pkg::REG_AW-1:0]      rs1_addr_i,
    input  logic [rvm_pkg::REG_AW-1:0]      rs2_addr_i,
    input  rvm_pkg::rvm_wb_t                wb_i,
    input  logic                            load_we_i,
    input  logic [rvm_pkg::REG_AW-1:0]      load_addr_i,
    input  logic [`RVM_XLEN-1:0]            load_data_i,

    output logic [`RVM_XLEN-1:0]            rs1_data_o,
    output logic [`RVM_XLEN-1:0]            rs2_data_o,
    output rvm_pkg::rvm_wb_t                wb_o
);

    import rvm_pkg::*;

    localparam int unsigned NREGS = `RVM_NREGS;

    logic [`RVM_XLEN-1:0] regs_q [NREGS];
    logic                 wb_write;

    assign wb_write = wb_i.valid && wb_i.we && wb_i.rd != '0;

    // Write-through: the result on the write port is visible in the same cycle
    function automatic logic [`RVM_XLEN-1:0] read_port(input logic [REG_AW-1:0] addr);
        logic [`RVM_XLEN-1:0] data;
        data = regs_q[addr];
        if (wb_write && wb_i.rd == addr) begin
            data = wb_i.result;
        end
        return data;
    endfunction

    assign rs1_data_o = read_port(rs1_addr_i);
    assign rs2_data_o = read_port(rs2_addr_i);

    // x0 is cleared by reset and never written
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else begin
            if (load_we_i && load_addr_i != '0) begin
                regs_q[load_addr_i] <= load_data_i;
            end
            // Later assignment, so writeback wins on the same register
            if (wb_write) begin
                regs_q[wb_i.rd] <= wb_i.result;
            end
        end
    end

    assign wb_o = wb_i;

endmodule : rvm_regfile

`default_nettype wire

// ==== logic/rvm_unit.sv ====
`default_nettype none

`include "rvm_settings.svh"

module rvm_unit (
    input  logic                            clk_i,
    input  logic                            arst_n_i,

    // Issue port
    input  logic                            instr_valid_i,
    input  rvm_pkg::rvm_instr_u             instr_i,
    input  logic [`RVM_ID_W-1:0]            instr_id_i,
    output logic                            instr_ready_o,

    // Register preset
    input  logic                            load_we_i,
    input  logic [rvm_pkg::REG_AW-1:0]      load_addr_i,
    input  logic [`RVM_XLEN-1:0]            load_data_i,

    output rvm_pkg::rvm_wb_t                wb_o
);

    import rvm_pkg::*;

    logic [REG_AW-1:0]                 rs1_addr;
    logic [REG_AW-1:0]                 rs2_addr;
    logic [`RVM_XLEN-1:0]              rs1_data;
    logic [`RVM_XLEN-1:0]              rs2_data;
    logic                              issue_valid;
    rvm_issue_t                        issue;
    rvm_dest_t [`RVM_STAGES-1:0]       stage_dest;
    rvm_wb_t                           wb;

    rvm_decode u_decode (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_id_i    (instr_id_i),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .stage_dest_i  (stage_dest),
        .instr_ready_o (instr_ready_o),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .issue_valid_o (issue_valid),
        .issue_o       (issue)
    );

    rvm_pipeline u_pipeline (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .issue_valid_i (issue_valid),
        .issue_i       (issue),
        .stage_dest_o  (stage_dest),
        .wb_o          (wb)
    );

    rvm_regfile u_regfile (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .rs1_addr_i    (rs1_addr),
        .rs2_addr_i    (rs2_addr),
        .wb_i          (wb),
        .load_we_i     (load_we_i),
        .load_addr_i   (load_addr_i),
        .load_data_i   (load_data_i),
        .rs1_data_o    (rs1_data),
        .rs2_data_o    (rs2_data),
        .wb_o          (wb_o)
    );

endmodule : rvm_unit

`default_nettype wire

// ==== testbench/rvm_tb_clk.sv ====
`default_nettype none

module rvm_tb_clk #(
    parameter int unsigned RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    timeunit 1ns;
    timeprecision 1ps;

    // 10 ns period
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        arst_n_o = 1'b1;
    end

endmodule : rvm_tb_clk

`default_nettype wire

// ==== testbench/rvm_chk.sv ====
`default_nettype none

`include "rvm_settings.svh"

module rvm_chk (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        instr_valid_i,
    input  rvm_pkg::rvm_instr_u         instr_i,
    input  logic [`RVM_ID_W-1:0]        instr_id_i,
    input  logic                        instr_ready_i,
    input  rvm_pkg::rvm_wb_t            wb_i
);

    timeunit 1ns;
    timeprecision 1ps;

    import rvm_pkg::*;

    logic m_word;

    assign m_word = (instr_i.raw & 32'hfe00_007f) == 32'h0200_0033;

    // Source holds a stalled word
    stall_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        instr_valid_i && !instr_ready_i |=> $stable(instr_i) && $stable(instr_id_i))
        else $error("issue word changed while stalled");

    wb_quiet_after_reset: assert property (@(posedge clk_i)
        $rose(arst_n_i) |-> !wb_i.valid)
        else $error("writeback valid high right after reset");

    // Not an M word, so nothing to wait for
    illegal_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !m_word |-> instr_ready_i)
        else $error("illegal word held by the issue port");

endmodule : rvm_chk

bind rvm_unit rvm_chk u_chk (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .instr_id_i    (instr_id_i),
    .instr_ready_i (instr_ready_o),
    .wb_i          (wb_o)
);

`default_nettype wire

// ==== testbench/rvm_tb.sv ====
`default_nettype none

`include "rvm_settings.svh"

module rvm_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rvm_pkg::*;

    localparam int unsigned TIMEOUT = 100;
    localparam int unsigned NROWS   = 17;
    localparam int unsigned NRAND   = 200;

    typedef struct packed {
        rvm_op_e     op;
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        logic [31:0] exp;
    } row_t;

    logic                 clk;
    logic                 arst_n;
    logic                 instr_valid;
    rvm_instr_u           instr;
    logic [`RVM_ID_W-1:0] instr_id;
    logic                 instr_ready;
    logic                 load_we;
    logic [REG_AW-1:0]    load_addr;
    logic [31:0]          load_data;
    rvm_wb_t              wb;

    int unsigned          cyc = 0;
    logic [31:0]          lfsr_state = 32'h0a63_5049;
    logic [31:0]          shadow [`RVM_NREGS];
    logic [`RVM_ID_W-1:0] next_id = '0;

    rvm_wb_t              exp_q [$];
    logic                 chk_q [$];
    int unsigned          cyc_q [$];

    row_t rows [NROWS] = '{
        '{OP_MUL,    32'd7,         32'd6,         5'd3,  32'h0000_002a},
        '{OP_MUL,    32'hffff_ffff, 32'hffff_ffff, 5'd4,  32'h0000_0001},
        '{OP_MULH,   32'hffff_ffff, 32'hffff_ffff, 5'd5,  32'h0000_0000},
        '{OP_MULH,   32'h8000_0000, 32'h8000_0000, 5'd6,  32'h4000_0000},
        '{OP_MULHU,  32'hffff_ffff, 32'hffff_ffff, 5'd7,  32'hffff_fffe},
        '{OP_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 5'd8,  32'hffff_ffff},
        '{OP_MULHSU, 32'd2,         32'h8000_0000, 5'd9,  32'h0000_0001},
        '{OP_DIV,    32'hffff_fff9, 32'd2,         5'd10, 32'hffff_fffd},
        '{OP_DIV,    32'd5,         32'd0,         5'd11, 32'hffff_ffff},
        '{OP_DIV,    32'h8000_0000, 32'hffff_ffff, 5'd12, 32'h8000_0000},
        '{OP_DIVU,   32'hffff_fff9, 32'd2,         5'd13, 32'h7fff_fffc},
        '{OP_DIVU,   32'd5,         32'd0,         5'd14, 32'hffff_ffff},
        '{OP_REM,    32'hffff_fff9, 32'd2,         5'd15, 32'hffff_ffff},
        '{OP_REM,    32'd5,         32'd0,         5'd16, 32'h0000_0005},
        '{OP_REM,    32'h8000_0000, 32'hffff_ffff, 5'd17, 32'h0000_0000},
        '{OP_REMU,   32'hffff_fff9, 32'd2,         5'd18, 32'h0000_0001},
        '{OP_REMU,   32'd9,         32'd0,         5'd19, 32'h0000_0009}
    };

    rvm_tb_clk #(.RESET_CYCLES(8)) u_clk (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    rvm_unit u_dut (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .instr_id_i    (instr_id),
        .instr_ready_o (instr_ready),
        .load_we_i     (load_we),
        .load_addr_i   (load_addr),
        .load_data_i   (load_data),
        .wb_o          (wb)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic fail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        fail($sformatf("CHECK FAILED t=%0t %s expected 0x%08h got 0x%08h",
                       $time, name, exp, got));
    endtask

    task automatic check_ready(input logic exp);
        if (instr_ready !== exp) begin
            report_value("instr_ready_o", 32'(exp), 32'(instr_ready));
        end
    endtask

    task automatic check_wb(input rvm_wb_t exp, input logic chk_res, input rvm_wb_t got);
        if (chk_res && got.result !== exp.result) begin
            report_value("wb_o.result", exp.result, got.result);
        end
        if (got.rd !== exp.rd) report_value("wb_o.rd", 32'(exp.rd), 32'(got.rd));
        if (got.we !== exp.we) report_value("wb_o.we", 32'(exp.we), 32'(got.we));
        if (got.illegal !== exp.illegal) begin
            report_value("wb_o.illegal", 32'(exp.illegal), 32'(got.illegal));
        end
        if (got.id !== exp.id) report_value("wb_o.id", 32'(exp.id), 32'(got.id));
    endtask

    // Galois form with one step per bit
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    // Reference model with 64-bit products and the RISC-V division corner cases
    function automatic logic [31:0] ref_result(input rvm_op_e op, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic        [63:0] ua;
        logic        [63:0] ub;
        logic        [63:0] p;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        p  = '0;
        case (op)
            OP_MUL:    p = sa * sb;
            OP_MULH:   p = {(sa * sb) >> 32};
            OP_MULHSU: p = {(sa * $signed(ub)) >> 32};
            OP_MULHU:  p = (ua * ub) >> 32;
            OP_DIV: begin
                if (b == 0) p = '1;
                else if (a == 32'h8000_0000 && b == 32'hffff_ffff) p = ua;
                else p = sa / sb;
            end
            OP_DIVU:   p = (b == 0) ? '1 : ua / ub;
            OP_REM: begin
                if (b == 0) p = ua;
                else if (a == 32'h8000_0000 && b == 32'hffff_ffff) p = '0;
                else p = sa % sb;
            end
            default:   p = (b == 0) ? ua : ua % ub;
        endcase
        return p[31:0];
    endfunction

    function automatic rvm_instr_u encode(input rvm_op_e op, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [4:0] rs2);
        rvm_instr_u w;
        w.r.funct7 = 7'b000_0001;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = op;
        w.r.rd     = rd;
        w.r.opcode = 7'b011_0011;
        return w;
    endfunction

    // Tasks start and end on a falling edge
    task automatic load_reg(input logic [4:0] addr, input logic [31:0] data);
        load_we   = 1'b1;
        load_addr = addr;
        load_data = data;
        @(negedge clk);
        load_we = 1'b0;
        if (addr != 0) shadow[addr] = data;
    endtask

    // With ready_at nonzero, ready must stay low before that cycle and be high from it
    task automatic issue(input rvm_instr_u word, input int unsigned ready_at,
                         output int unsigned acc);
        int unsigned t;
        t           = 0;
        instr_valid = 1'b1;
        instr       = word;
        instr_id    = next_id;
        forever begin
            #1;
            if (ready_at != 0) check_ready(cyc >= ready_at);
            if (instr_ready) break;
            @(negedge clk);
            t++;
            if (t > TIMEOUT) fail("issue port never accepted the instruction");
        end
        @(negedge clk);
        acc         = cyc;
        instr_valid = 1'b0;
        next_id     = next_id + 4'd1;
    endtask

    task automatic expect_wb(input rvm_wb_t e, input logic chk_res, input rvm_instr_u word,
                             input int unsigned ready_at, output int unsigned acc);
        exp_q.push_back(e);
        chk_q.push_back(chk_res);
        issue(word, ready_at, acc);
        cyc_q.push_back(acc + 4);
    endtask

    task automatic issue_op(input rvm_op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                            input logic [4:0] rs2, input int unsigned ready_at,
                            output int unsigned acc);
        rvm_wb_t e;
        e.valid   = 1'b1;
        e.result  = ref_result(op, shadow[rs1], shadow[rs2]);
        e.rd      = rd;
        e.we      = rd != 0;
        e.illegal = 1'b0;
        e.id      = next_id;
        expect_wb(e, 1'b1, encode(op, rd, rs1, rs2), ready_at, acc);
        if (rd != 0) shadow[rd] = e.result;
    endtask

    task automatic drain();
        int unsigned t;
        t = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            t++;
            if (t > TIMEOUT) fail("writeback never arrived for an issued instruction");
        end
    endtask

    // Writeback monitor sampling mid-cycle
    always @(negedge clk) begin
        rvm_wb_t     e;
        logic        c;
        int unsigned t;
        if (arst_n && wb.valid) begin
            if (exp_q.size() == 0) begin
                fail("writeback seen with no instruction in flight");
            end else begin
                e = exp_q.pop_front();
                c = chk_q.pop_front();
                t = cyc_q.pop_front();
                if (cyc != t) report_value("wb_o.valid cycle", t, cyc);
                check_wb(e, c, wb);
            end
        end
    end

    initial begin
        int unsigned acc;
        int unsigned prev;
        int unsigned t;
        rvm_instr_u  w;
        rvm_wb_t     e;
        logic [31:0] r;
        rvm_op_e     op;

        instr_valid = 1'b0;
        instr       = '0;
        instr_id    = '0;
        load_we     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        for (int i = 0; i < `RVM_NREGS; i++) shadow[i] = '0;

        t = 0;
        do begin
            @(posedge clk);
            t++;
            if (t > TIMEOUT) fail("reset was never released");
        end while (arst_n !== 1'b1);
        @(negedge clk);

        // Idle state after reset
        #1;
        if (wb.valid !== 1'b0) report_value("wb_o.valid", 32'd0, 32'(wb.valid));
        check_ready(1'b1);

        // Operation table
        for (int i = 0; i < NROWS; i++) begin
            r = ref_result(rows[i].op, rows[i].a, rows[i].b);
            if (r !== rows[i].exp) fail($sformatf("reference model disagrees with row %0d", i));
            load_reg(5'd1, rows[i].a);
            load_reg(5'd2, rows[i].b);
            issue_op(rows[i].op, rows[i].rd, 5'd1, 5'd2, 0, acc);
        end
        drain();

        // Five independent instructions back to back
        load_reg(5'd1, 32'h1234_5678);
        load_reg(5'd2, 32'h0000_0013);
        for (int i = 0; i < 5; i++) begin
            issue_op(rvm_op_e'(3'(i)), 5'(20 + i), 5'd1, 5'd2, 0, acc);
            if (i > 0 && acc != prev + 1) report_value("issue accept cycle", prev + 1, acc);
            prev = acc;
        end
        drain();

        // Dependent chain stalled until each producer reaches writeback
        load_reg(5'd1, 32'd7);
        load_reg(5'd2, 32'd3);
        issue_op(OP_MUL, 5'd5, 5'd1, 5'd2, 0, prev);
        issue_op(OP_MUL, 5'd6, 5'd5, 5'd2, prev + 4, acc);
        issue_op(OP_MUL, 5'd7, 5'd2, 5'd6, acc + 4, prev);
        drain();

        // Illegal word and a write to x0 leave the registers alone
        load_reg(5'd10, 32'hcafe_1234);
        issue_op(OP_MUL, 5'd11, 5'd1, 5'd2, 0, prev);
        // An illegal word is accepted even with its rs1 in flight
        w          = encode(OP_MUL, 5'd10, 5'd11, 5'd2);
        w.r.funct7 = 7'b000_0000;
        e          = '0;
        e.valid    = 1'b1;
        e.rd       = 5'd10;
        e.illegal  = 1'b1;
        e.id       = next_id;
        expect_wb(e, 1'b0, w, prev, acc);
        issue_op(OP_MUL, 5'd0, 5'd1, 5'd2, 0, acc);
        drain();
        load_reg(5'd12, 32'd1);
        issue_op(OP_MUL, 5'd13, 5'd10, 5'd12, 0, acc);
        issue_op(OP_MUL, 5'd14, 5'd0, 5'd12, 0, acc);
        drain();

        // Random operations
        for (int i = 0; i < NRAND; i++) begin
            r  = lfsr_bits(3);
            op = rvm_op_e'(r[2:0]);
            load_reg(5'd1, lfsr_bits(32));
            r = lfsr_bits(32);
            if (lfsr_bits(4) == 0) r = '0;
            load_reg(5'd2, r);
            r = lfsr_bits(5);
            issue_op(op, 5'(3 + r % 29), 5'd1, 5'd2, 0, acc);
        end
        drain();

        $display("TB PASSED");
        $finish;
    end

endmodule : rvm_tb

`default_nettype wire

// ==== tb.f ====
+incdir+logic
logic/rvm_pkg.sv
logic/rvm_decode.sv
logic/rvm_pipeline.sv
logic/rvm_regfile.sv
logic/rvm_unit.sv
testbench/rvm_tb_clk.sv
testbench/rvm_chk.sv
testbench/rvm_tb.sv

// ==== Makefile ====
# Verilator build of the M-extension unit testbench

VERILATOR ?= verilator
TOP       ?= rvm_tb
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Exit status of the simulation is the result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
